/* ulpb_pkg.sv */
`default_nettype none

package ulpb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// message format.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int ULPB_ADDR_W = 8;
	localparam int ULPB_DATA_W = 32;
	localparam int ULPB_MSG_W = ULPB_ADDR_W + ULPB_DATA_W;

	// address goes out first, both fields MSB first.
	typedef struct packed {
		logic [ULPB_ADDR_W-1:0] addr;
		logic [ULPB_DATA_W-1:0] data;
	} ulpb_msg_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// node sequencer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		BUS_IDLE,
		ARBI_RESOLVED,
		DRIVE1,
		LATCH1,
		DRIVE2,
		LATCH2,
		BUS_RESET
	} node_state_t;

	typedef enum logic [1:0] {
		MODE_IDLE,
		MODE_TX,
		MODE_RX,
		MODE_FWD
	} node_mode_t;

endpackage

`default_nettype wire

/* ulpb_tx_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpb_tx_queue #(
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic                CLK,
	input  logic                RESET,
	input  logic                push,
	input  ulpb_pkg::ulpb_msg_t push_msg,
	input  logic                ack_tx,
	output logic                full,
	output logic                req,
	output ulpb_pkg::ulpb_msg_t head_msg
);

	import ulpb_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	ulpb_msg_t mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic ack_d;
	logic do_push;
	logic do_pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(QUEUE_DEPTH));
	assign do_push = push && !full;
	assign do_pop = ack_tx && !ack_d && (count != '0);

	// req drops while ack_tx is high, so the node can release it.
	assign req = (count != '0) && !ack_tx;
	assign head_msg = mem[rd_ptr];

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ack_d <= 1'b0;
		end
		else
		begin
			ack_d <= ack_tx;
			if (do_push)
				wr_ptr <= ptr_next(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_msg;
	end

endmodule

`default_nettype wire

/* ulpb_node.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpb_node #(
	parameter int RESET_CNT = 2,
	parameter logic [ulpb_pkg::ULPB_ADDR_W-1:0] ADDRESS = '0
)
(
	input  logic                CLK,
	input  logic                RESET,
	input  logic                din,
	input  ulpb_pkg::ulpb_msg_t tx_msg,
	input  logic                req_tx,
	input  logic                rx_ack,
	output logic                dout,
	output logic                ack_tx,
	output ulpb_pkg::ulpb_msg_t rx_msg,
	output logic                rx_req,
	output logic                ack_received
);

	import ulpb_pkg::*;

	localparam int CNT_W = $clog2(ULPB_MSG_W);
	localparam int RC_W = (RESET_CNT > 0) ? $clog2(RESET_CNT + 1) : 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	node_state_t state;
	node_mode_t mode;
	logic [CNT_W-1:0] bit_cnt;
	logic eom;
	logic [RC_W-1:0] rst_cnt;
	logic latch1_sample;

	logic [ULPB_MSG_W-1:0] tx_shift;
	logic [ULPB_MSG_W-1:0] rx_shift;

	logic win;
	logic bit_end;
	logic [1:0] edge_buf;
	logic ack_edge;
	logic [ULPB_ADDR_W-1:0] addr_seen;

	// we win when we pull the idle line and nobody upstream pulled it first.
	assign win = (state == BUS_IDLE) && req_tx && din;
	assign bit_end = (state == LATCH2) && !eom;

	// the acknowledge is a falling edge between the LATCH1 and LATCH2 samples.
	assign edge_buf = {latch1_sample, din};
	assign ack_edge = edge_buf[1] & ~edge_buf[0];

	// address as it stands once the last address bit is sampled.
	assign addr_seen = {rx_shift[ULPB_ADDR_W-2:0], din};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line output.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a data cell reads 0,b,b,b and the end mark reads 0,1,1,1.
	// the addressed node answers the end mark with 1,1,0,0.
	always_comb
	begin
		dout = din;
		case (state)
			BUS_IDLE:
			begin
				dout = din & ~req_tx;
			end

			ARBI_RESOLVED:
			begin
				if (mode == MODE_TX)
					dout = 1'b0;
			end

			BUS_RESET:
			begin
				dout = 1'b1;
			end

			default:
			begin
				if (mode == MODE_TX)
				begin
					if (state == DRIVE1)
						dout = 1'b0;
					else
						dout = eom | tx_shift[ULPB_MSG_W-1];
				end
				else if ((mode == MODE_RX) && eom)
					dout = (state == DRIVE1) || (state == LATCH1);
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			state <= BUS_IDLE;
			mode <= MODE_IDLE;
			bit_cnt <= '0;
			eom <= 1'b0;
			rst_cnt <= '0;
			latch1_sample <= 1'b0;
			ack_tx <= 1'b0;
			rx_req <= 1'b0;
			ack_received <= 1'b0;
		end
		else
		begin
			// host handshake levels.
			if (ack_tx && !req_tx)
				ack_tx <= 1'b0;
			if (rx_req && rx_ack)
				rx_req <= 1'b0;

			case (state)
				BUS_IDLE:
				begin
					// a low line at our output starts the transaction for us.
					if (!dout)
					begin
						state <= ARBI_RESOLVED;
						bit_cnt <= CNT_W'(ULPB_MSG_W - 1);
						if (win)
						begin
							mode <= MODE_TX;
							ack_tx <= 1'b1;
						end
						else
							mode <= MODE_RX;
					end
				end

				ARBI_RESOLVED:
				begin
					state <= DRIVE1;
				end

				DRIVE1:
				begin
					state <= LATCH1;
				end

				LATCH1:
				begin
					state <= DRIVE2;
					latch1_sample <= din;
				end

				DRIVE2:
				begin
					state <= LATCH2;
				end

				LATCH2:
				begin
					if (eom)
					begin
						state <= BUS_RESET;
						rst_cnt <= RC_W'(RESET_CNT);
						if (mode == MODE_TX)
							ack_received <= ack_edge;
					end
					else
					begin
						state <= DRIVE1;
						// last address bit, keep the message or pass it on.
						if ((mode == MODE_RX) && (bit_cnt == CNT_W'(ULPB_DATA_W)))
							mode <= (addr_seen == ADDRESS) ? MODE_RX : MODE_FWD;
						if (bit_cnt == '0)
						begin
							eom <= 1'b1;
							if (mode == MODE_RX)
								rx_req <= 1'b1;
						end
						else
							bit_cnt <= bit_cnt - 1'b1;
					end
				end

				BUS_RESET:
				begin
					if (rst_cnt == '0)
					begin
						state <= BUS_IDLE;
						mode <= MODE_IDLE;
						eom <= 1'b0;
						ack_received <= 1'b0;
					end
					else
						rst_cnt <= rst_cnt - 1'b1;
				end

				default:
				begin
					state <= BUS_IDLE;
				end
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shift registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge CLK)
	begin
		if (win)
			tx_shift <= tx_msg;
		else if (bit_end)
			tx_shift <= {tx_shift[ULPB_MSG_W-2:0], 1'b0};

		// every listener shifts the address in.
		if (bit_end && (mode != MODE_TX))
			rx_shift <= {rx_shift[ULPB_MSG_W-2:0], din};

		// rx_msg holds until the next message for this address.
		if (bit_end && (mode == MODE_RX) && (bit_cnt == '0))
			rx_msg <= ulpb_msg_t'({rx_shift[ULPB_MSG_W-2:0], din});
	end

endmodule

`default_nettype wire

/* ulpb_ring_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpb_ring_ctrl #(
	parameter int RESET_CNT = 2
)
(
	input  logic CLK,
	input  logic RESET,
	input  logic line_in,
	output logic line_out,
	output logic bus_busy
);

	// no bit cell keeps the line high this long.
	localparam int HOLD = RESET_CNT + 4;
	localparam int HC_W = $clog2(HOLD + 1);

	logic [HC_W-1:0] high_cnt;

	// the only register in the ring, idle level is high.
	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
			line_out <= 1'b1;
		else
			line_out <= line_in;
	end

	always_ff @(posedge CLK or negedge RESET)
	begin
		if (!RESET)
		begin
			bus_busy <= 1'b0;
			high_cnt <= '0;
		end
		else if (!line_in)
		begin
			bus_busy <= 1'b1;
			high_cnt <= '0;
		end
		else if (bus_busy)
		begin
			if (high_cnt == HC_W'(HOLD))
				bus_busy <= 1'b0;
			else
				high_cnt <= high_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* ulpb_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpb_ring #(
	parameter int NODES = 3,
	parameter logic [ulpb_pkg::ULPB_ADDR_W-1:0] ADDR_BASE = 8'hA0,
	parameter int RESET_CNT = 2,
	parameter int QUEUE_DEPTH = 4
)
(
	input  logic                CLK,
	input  logic                RESET,
	input  logic [NODES-1:0]    push,
	input  ulpb_pkg::ulpb_msg_t push_msg [NODES],
	input  logic [NODES-1:0]    rx_ack,
	output logic [NODES-1:0]    full,
	output logic [NODES-1:0]    rx_req,
	output logic [NODES-1:0]    ack_received,
	output ulpb_pkg::ulpb_msg_t rx_msg [NODES],
	output logic                bus_busy
);

	import ulpb_pkg::*;

	logic line_in;
	logic line_out;

	genvar k;
	generate
		for (k = 0; k < NODES; k++)
		begin : g_node
			logic node_in;
			logic node_out;
			logic req;
			logic ack_tx;
			ulpb_msg_t head_msg;

			// node 0 hangs off the controller, the others off their neighbour.
			if (k == 0)
			begin : g_head
				assign node_in = line_out;
			end
			else
			begin : g_link
				assign node_in = g_node[k-1].node_out;
			end

			ulpb_tx_queue #(
				.QUEUE_DEPTH(QUEUE_DEPTH)
			) queue_i (
				.CLK(CLK),
				.RESET(RESET),
				.push(push[k]),
				.push_msg(push_msg[k]),
				.ack_tx(ack_tx),
				.full(full[k]),
				.req(req),
				.head_msg(head_msg)
			);

			ulpb_node #(
				.RESET_CNT(RESET_CNT),
				.ADDRESS(ULPB_ADDR_W'(ADDR_BASE + k))
			) node_i (
				.CLK(CLK),
				.RESET(RESET),
				.din(node_in),
				.tx_msg(head_msg),
				.req_tx(req),
				.rx_ack(rx_ack[k]),
				.dout(node_out),
				.ack_tx(ack_tx),
				.rx_msg(rx_msg[k]),
				.rx_req(rx_req[k]),
				.ack_received(ack_received[k])
			);
		end
	endgenerate

	// last node closes the ring back into the controller.
	assign line_in = g_node[NODES-1].node_out;

	ulpb_ring_ctrl #(
		.RESET_CNT(RESET_CNT)
	) ctrl_i (
		.CLK(CLK),
		.RESET(RESET),
		.line_in(line_in),
		.line_out(line_out),
		.bus_busy(bus_busy)
	);

endmodule

`default_nettype wire

/* ulpb_ring_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module ulpb_ring_sva #(
	parameter int NODES = 3
)
(
	input wire logic             CLK,
	input wire logic             RESET,
	input wire logic [NODES-1:0] rx_req,
	input wire logic [NODES-1:0] rx_ack,
	input wire logic             line_out
);

	import ulpb_pkg::*;

	logic [NODES-1:0] tx_vec;
	logic [NODES-1:0] idle_vec;

	genvar k;
	generate
		for (k = 0; k < NODES; k++)
		begin : g_chk
			assign tx_vec[k] = (g_node[k].node_i.mode == MODE_TX);
			assign idle_vec[k] = (g_node[k].node_i.state == BUS_IDLE);

			rx_req_held: assert property (@(posedge CLK) disable iff (!RESET)
				rx_req[k] && !rx_ack[k] |=> rx_req[k])
				else $error("rx_req dropped before rx_ack");

			ack_tx_needs_req: assert property (@(posedge CLK) disable iff (!RESET)
				$rose(g_node[k].ack_tx) |-> $past(g_node[k].req))
				else $error("ack_tx rose while req was low");
		end
	endgenerate

	// the idle ring rests high.
	idle_line_high: assert property (@(posedge CLK) disable iff (!RESET)
		&idle_vec |-> line_out)
		else $error("line_out low while every node is idle");

	single_sender: assert property (@(posedge CLK) disable iff (!RESET)
		$onehot0(tx_vec))
		else $error("more than one node transmitting");

endmodule

bind ulpb_ring ulpb_ring_sva #(
	.NODES(NODES)
) ulpb_ring_sva_i (
	.CLK(CLK),
	.RESET(RESET),
	.rx_req(rx_req),
	.rx_ack(rx_ack),
	.line_out(line_out)
);

`default_nettype wire

/* tb_ulpb_ring.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ulpb_ring;

	import ulpb_pkg::*;

	localparam int NODES = 3;
	localparam logic [ULPB_ADDR_W-1:0] ADDR_BASE = 8'hA0;
	localparam int QUEUE_DEPTH = 4;
	localparam int MSG_COUNT = 9;
	// one transaction is four cycles per bit, the end mark, reset and margin.
	localparam int TXN_CYCLES = 4 * (ULPB_MSG_W + 1) + 40;
	localparam int WATCHDOG_CYCLES = 6 * TXN_CYCLES * MSG_COUNT;
	localparam int WAIT_CYCLES = 8 * TXN_CYCLES;

	logic CLK;
	logic RESET;
	logic [NODES-1:0] push;
	ulpb_msg_t push_msg [NODES];
	logic [NODES-1:0] rx_ack;
	logic [NODES-1:0] full;
	logic [NODES-1:0] rx_req;
	logic [NODES-1:0] ack_received;
	ulpb_msg_t rx_msg [NODES];
	logic bus_busy;

	int errors = 0;
	int ack_delay [NODES];
	int ack_count [NODES];
	logic [NODES-1:0] ack_prev;
	ulpb_msg_t rx_log [NODES][$];

	ulpb_ring #(
		.NODES(NODES),
		.ADDR_BASE(ADDR_BASE),
		.RESET_CNT(2),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) ulpb_ring_i (
		.CLK(CLK),
		.RESET(RESET),
		.push(push),
		.push_msg(push_msg),
		.rx_ack(rx_ack),
		.full(full),
		.rx_req(rx_req),
		.ack_received(ack_received),
		.rx_msg(rx_msg),
		.bus_busy(bus_busy)
	);

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// counts ack_received pulses per node.
	always @(posedge CLK)
	begin
		for (int k = 0; k < NODES; k++)
			if (ack_received[k] && !ack_prev[k])
				ack_count[k]++;
		ack_prev <= ack_received;
	end

	// host side of one node's receive handshake.
	task automatic answer_rx(input int n);
		ulpb_msg_t msg;
		forever
		begin
			@(posedge CLK);
			if (rx_req[n] && !rx_ack[n])
			begin
				msg = rx_msg[n];
				repeat (ack_delay[n]) @(posedge CLK);
				#1 rx_ack[n] = 1'b1;
				do
					@(posedge CLK);
				while (rx_req[n]);
				#1 rx_ack[n] = 1'b0;
				rx_log[n].push_back(msg);
			end
		end
	endtask

	task automatic wait_rx(input int n, input int count);
		int t;
		t = 0;
		while ((rx_log[n].size() < count) && (t < WAIT_CYCLES))
		begin
			@(posedge CLK);
			t++;
		end
		if (rx_log[n].size() < count)
		begin
			$display("no message arrived at node %0d by %0t", n, $time);
			errors++;
		end
		#1;
	endtask

	task automatic wait_bus(input logic level);
		int t;
		t = 0;
		while ((bus_busy !== level) && (t < WAIT_CYCLES))
		begin
			@(posedge CLK);
			t++;
		end
		if (bus_busy !== level)
		begin
			$display("bus_busy never went %0d by %0t", level, $time);
			errors++;
		end
		#1;
	endtask

	// sets one push for the next edge, the caller clears it.
	task automatic load_push(input int n, input logic [ULPB_ADDR_W-1:0] addr,
		input logic [ULPB_DATA_W-1:0] data);
		check_value($sformatf("full[%0d] before push", n), 0, full[n]);
		push[n] = 1'b1;
		push_msg[n].addr = addr;
		push_msg[n].data = data;
	endtask

	task automatic send(input int n, input logic [ULPB_ADDR_W-1:0] addr,
		input logic [ULPB_DATA_W-1:0] data);
		load_push(n, addr, data);
		step();
		push = '0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_reset_state();
		check_value("rx_req", 0, rx_req);
		check_value("ack_received", 0, ack_received);
		check_value("bus_busy", 0, bus_busy);
		check_value("full", 0, full);
	endtask

	task automatic test_single_send();
		logic [ULPB_DATA_W-1:0] data;
		int n1;
		int n2;
		int acks;
		data = $urandom;
		n1 = rx_log[1].size();
		n2 = rx_log[2].size();
		acks = ack_count[0];
		send(0, ADDR_BASE + 2, data);
		wait_rx(2, n2 + 1);
		wait_bus(1'b0);
		check_value("node 1 message count", n1, rx_log[1].size());
		check_value("node 2 rx addr", ADDR_BASE + 2, rx_log[2][n2].addr);
		check_value("node 2 rx data", data, rx_log[2][n2].data);
		check_value("node 0 ack pulses", acks + 1, ack_count[0]);
	endtask

	task automatic test_no_target();
		int sizes [NODES];
		int acks;
		for (int k = 0; k < NODES; k++)
			sizes[k] = rx_log[k].size();
		acks = ack_count[0];
		send(0, ADDR_BASE + 5, $urandom);
		wait_bus(1'b1);
		wait_bus(1'b0);
		for (int k = 0; k < NODES; k++)
			check_value($sformatf("node %0d message count", k), sizes[k], rx_log[k].size());
		check_value("rx_req", 0, rx_req);
		check_value("node 0 ack pulses", acks, ack_count[0]);
	endtask

	task automatic test_arbitration();
		logic [ULPB_DATA_W-1:0] data1;
		logic [ULPB_DATA_W-1:0] data2;
		int n0;
		int acks1;
		int acks2;
		data1 = $urandom;
		data2 = $urandom;
		n0 = rx_log[0].size();
		acks1 = ack_count[1];
		acks2 = ack_count[2];
		load_push(1, ADDR_BASE, data1);
		load_push(2, ADDR_BASE, data2);
		step();
		push = '0;
		wait_rx(0, n0 + 2);
		wait_bus(1'b0);
		check_value("first rx addr", ADDR_BASE, rx_log[0][n0].addr);
		check_value("first rx data", data1, rx_log[0][n0].data);
		check_value("second rx addr", ADDR_BASE, rx_log[0][n0 + 1].addr);
		check_value("second rx data", data2, rx_log[0][n0 + 1].data);
		check_value("node 1 ack pulses", acks1 + 1, ack_count[1]);
		check_value("node 2 ack pulses", acks2 + 1, ack_count[2]);
	endtask

	task automatic test_queue_burst();
		logic [ULPB_DATA_W-1:0] words [QUEUE_DEPTH];
		logic [ULPB_DATA_W-1:0] lead;
		int n0;
		int n1;
		n0 = rx_log[0].size();
		n1 = rx_log[1].size();
		ack_delay[0] = 25;
		// a message from node 0 holds the bus so node 2 cannot drain its queue.
		lead = $urandom;
		send(0, ADDR_BASE + 1, lead);
		wait_bus(1'b1);
		for (int i = 0; i < QUEUE_DEPTH; i++)
		begin
			words[i] = $urandom;
			send(2, ADDR_BASE, words[i]);
		end
		check_value("full[2]", 1, full[2]);
		wait_rx(1, n1 + 1);
		check_value("lead rx data", lead, rx_log[1][n1].data);
		wait_rx(0, n0 + QUEUE_DEPTH);
		wait_bus(1'b0);
		for (int i = 0; i < QUEUE_DEPTH; i++)
		begin
			check_value($sformatf("burst %0d addr", i), ADDR_BASE, rx_log[0][n0 + i].addr);
			check_value($sformatf("burst %0d data", i), words[i], rx_log[0][n0 + i].data);
		end
		check_value("full[2] after drain", 0, full[2]);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// run.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		void'($urandom(32'h9ba8_92a1));
		RESET = 1'b0;
		push = '0;
		rx_ack = '0;
		for (int k = 0; k < NODES; k++)
		begin
			push_msg[k] = '0;
			ack_delay[k] = 4;
			ack_count[k] = 0;
		end
		ack_prev = '0;
		repeat (16) @(posedge CLK);
		#1 RESET = 1'b1;
		for (int k = 0; k < NODES; k++)
		begin
			fork
				automatic int n = k;
				answer_rx(n);
			join_none
		end
		step();
		test_reset_state();
		test_single_send();
		test_no_target();
		test_arbitration();
		test_queue_burst();
		repeat (4) step();
		$display("%0d errors", errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
ulpb_pkg.sv
ulpb_tx_queue.sv
ulpb_node.sv
ulpb_ring_ctrl.sv
ulpb_ring.sv
ulpb_ring_sva.sv
tb_ulpb_ring.sv

/* run.sh */
#!/bin/sh
# build and run the ring bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_ulpb_ring \
	-o sim_ulpb_ring > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_ulpb_ring > sim.log 2>&1
cat sim.log

grep -q "TESTBENCH PASSED" sim.log && exit 0 || exit 1
